/* Makefile */
# Verilator build and run of the streaming multiply testbench
# Any variable can be overridden, e.g. make run TOP=tb_simba LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_simba
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "Verification passed" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
verilog/simba_pkg.sv
verilog/simba_ctrl.sv
verilog/simba_reader.sv
verilog/simba_mul.sv
verilog/simba_writer.sv
verilog/simba_top.sv
tests/tb_simba_mem.sv
tests/tb_simba.sv

/* tests/tb_simba.sv */
module tb_simba import simba_pkg::*; ();

  localparam int unsigned NumJobs       = 8;
  localparam int unsigned MaxLen        = 24;
  // Long enough to stay busy over the meddling writes
  localparam int unsigned MeddleMinLen  = 12;
  localparam int unsigned MemWords      = 1024;
  localparam int unsigned StallMargin   = 16;
  localparam int unsigned SetupCycles   = 2000;
  localparam int unsigned TimeoutCycles = NumJobs * MaxLen * StallMargin + SetupCycles;
  localparam csr_data_t   AddrMask      = 32'h000f_ffff;
  localparam csr_data_t   LenMask       = 32'h0000_ffff;
  localparam csr_data_t   ShiftMask     = 32'h0000_001f;

  logic                          clk;
  logic                          rst;
  csr_addr_t                     csr_req_addr;
  csr_data_t                     csr_req_data;
  logic                          csr_req_write;
  logic                          csr_req_valid;
  logic                          csr_req_ready;
  csr_data_t                     csr_rsp_data;
  logic                          csr_rsp_valid;
  logic                          csr_rsp_ready;
  logic       [NumTcdmPorts-1:0] tcdm_req_valid;
  tcdm_addr_t [NumTcdmPorts-1:0] tcdm_req_addr;
  logic       [NumTcdmPorts-1:0] tcdm_req_write;
  data_t      [NumTcdmPorts-1:0] tcdm_req_wdata;
  logic       [NumTcdmPorts-1:0] tcdm_gnt;
  logic       [NumTcdmPorts-1:0] tcdm_rsp_valid;
  data_t      [NumTcdmPorts-1:0] tcdm_rsp_rdata;
  logic                          stall_en;

  // Reference memory and bookkeeping
  data_t       model_mem [MemWords];
  int unsigned cycle_count;
  int unsigned error_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned failed_tests;
  int unsigned test_errors_at_start;
  string       test_name;
  csr_data_t   expected_done;

  simba_top simba_top_inst (
    .clk_i (clk), .rst_i (rst),
    .csr_req_addr_i (csr_req_addr), .csr_req_data_i (csr_req_data),
    .csr_req_write_i (csr_req_write), .csr_req_valid_i (csr_req_valid),
    .csr_req_ready_o (csr_req_ready),
    .csr_rsp_data_o (csr_rsp_data), .csr_rsp_valid_o (csr_rsp_valid),
    .csr_rsp_ready_i (csr_rsp_ready),
    .tcdm_req_valid_o (tcdm_req_valid), .tcdm_req_addr_o (tcdm_req_addr),
    .tcdm_req_write_o (tcdm_req_write), .tcdm_req_wdata_o (tcdm_req_wdata),
    .tcdm_gnt_i (tcdm_gnt), .tcdm_rsp_valid_i (tcdm_rsp_valid),
    .tcdm_rsp_rdata_i (tcdm_rsp_rdata)
  );

  tb_simba_mem #(.Words (MemWords)) mem_inst (
    .clk_i (clk), .rst_i (rst), .stall_i (stall_en),
    .req_valid_i (tcdm_req_valid), .req_addr_i (tcdm_req_addr),
    .req_write_i (tcdm_req_write), .req_wdata_i (tcdm_req_wdata),
    .gnt_o (tcdm_gnt), .rsp_valid_o (tcdm_rsp_valid), .rsp_rdata_o (tcdm_rsp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the job count and worst stall rate
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: simulation still running after %0d cycles", cycle_count);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------
  // Compare and report
  // ----------------------------------------
  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_busy(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("** Failure at time %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic start_test(input string name);
    test_name            = name;
    test_errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_errors_at_start) begin
      $display("Test %0d %s: ok", test_count, test_name);
    end else begin
      $display("Test %0d %s: FAILED with %0d errors", test_count, test_name,
               error_count - test_errors_at_start);
      failed_tests++;
    end
  endtask

  // ----------------------------------------
  // CSR access
  // ----------------------------------------
  // Drive on the falling edge and return one cycle after the accept
  task automatic issue_request(input csr_addr_t addr, input csr_data_t data,
                               input logic write);
    @(negedge clk);
    csr_req_addr  = addr;
    csr_req_data  = data;
    csr_req_write = write;
    csr_req_valid = 1'b1;
    while (!csr_req_ready) @(negedge clk);
    @(negedge clk);
    csr_req_valid = 1'b0;
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    issue_request(addr, data, 1'b1);
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    issue_request(addr, '0, 1'b0);
    if (csr_rsp_valid !== 1'b1) begin
      report_failure($sformatf("no CSR response one cycle after read of 0x%0h", addr));
    end
    data = csr_rsp_data;
  endtask

  task automatic wait_idle();
    csr_data_t busy_word;
    busy_word = '1;
    while (busy_word[0]) csr_read(CsrBusy, busy_word);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_csr_regs();
    csr_addr_t regs [5]     = '{CsrBaseA, CsrBaseB, CsrBaseC, CsrLen, CsrShift};
    csr_data_t masks [5]    = '{AddrMask, AddrMask, AddrMask, LenMask, ShiftMask};
    csr_addr_t unmapped [4] = '{32'd8, 32'd15, 32'h100, 32'hdead_beef};
    csr_data_t written [5];
    csr_data_t rdata;
    start_test("CSR readback and unmapped reads");
    // Idle state straight out of reset
    check_busy("csr_req_ready_o", csr_req_ready, 1'b1);
    check_busy("csr_rsp_valid_o", csr_rsp_valid, 1'b0);
    if (tcdm_req_valid !== '0) report_failure("TCDM request active after reset");
    for (int i = 0; i < 5; i++) begin
      written[i] = $urandom;
      csr_write(regs[i], written[i]);
    end
    for (int i = 0; i < 5; i++) begin
      csr_read(regs[i], rdata);
      check_csr($sformatf("csr[%0d]", regs[i]), rdata, written[i] & masks[i]);
    end
    for (int i = 0; i < 4; i++) begin
      csr_read(unmapped[i], rdata);
      check_csr($sformatf("csr[0x%0h]", unmapped[i]), rdata, '0);
    end
    csr_read(CsrBusy, rdata);
    check_busy("busy", rdata[0], 1'b0);
    csr_read(CsrDoneCount, rdata);
    check_csr("done count", rdata, '0);
    end_test();
  endtask

  // Response held while the CSR master stalls
  task automatic test_rsp_stall();
    csr_data_t value;
    value = csr_data_t'($urandom_range(31, 1));
    start_test("CSR response back-pressure");
    csr_write(CsrShift, value);
    csr_rsp_ready = 1'b0;
    issue_request(CsrShift, '0, 1'b0);
    repeat (6) begin
      if (csr_rsp_valid !== 1'b1) report_failure("response valid dropped while stalled");
      if (csr_req_ready !== 1'b0) report_failure("request ready high with response pending");
      check_csr("csr_rsp_data_o", csr_rsp_data, value);
      @(negedge clk);
    end
    csr_rsp_ready = 1'b1;
    @(negedge clk);
    if (csr_rsp_valid !== 1'b0) report_failure("response still valid after release");
    if (csr_req_ready !== 1'b1) report_failure("request ready low after release");
    end_test();
  endtask

  task automatic fill_memory();
    for (int i = 0; i < MemWords; i++) begin
      mem_inst.mem[i] = $urandom;
      model_mem[i]    = mem_inst.mem[i];
    end
  endtask

  task automatic run_job(input int idx, input logic stalls, input logic meddle);
    int unsigned len;
    int unsigned shift;
    int unsigned wa;
    int unsigned wb;
    int unsigned wc;
    logic [63:0] prod;
    logic [63:0] scaled;
    csr_data_t   rdata;
    len   = meddle ? $urandom_range(MaxLen, MeddleMinLen) : $urandom_range(MaxLen, 1);
    shift = $urandom_range(31, 0);
    // Operand and result regions never overlap
    wa    = $urandom_range(100, 0);
    wb    = 256 + $urandom_range(100, 0);
    wc    = 512 + $urandom_range(100, 0);
    start_test($sformatf("job %0d len %0d shift %0d stalls %0d meddle %0d",
                         idx, len, shift, stalls, meddle));
    stall_en = stalls;
    fill_memory();
    for (int k = 0; k < len; k++) begin
      prod              = {32'h0, model_mem[wa+k]} * {32'h0, model_mem[wb+k]};
      scaled            = prod >> shift;
      model_mem[wc + k] = scaled[31:0];
    end
    csr_write(CsrBaseA, csr_data_t'(wa * 4));
    csr_write(CsrBaseB, csr_data_t'(wb * 4));
    csr_write(CsrBaseC, csr_data_t'(wc * 4));
    csr_write(CsrLen, csr_data_t'(len));
    csr_write(CsrShift, csr_data_t'(shift));
    csr_write(CsrStart, 32'h1);
    if (meddle) begin
      // All ignored while the job runs
      csr_write(CsrStart, 32'h1);
      csr_write(CsrLen, csr_data_t'(len - 3));
      csr_write(CsrShift, csr_data_t'((shift + 7) % 32));
      csr_write(CsrBaseC, 32'h0);
    end
    csr_read(CsrBusy, rdata);
    check_busy("busy", rdata[0], 1'b1);
    wait_idle();
    expected_done++;
    csr_read(CsrDoneCount, rdata);
    check_csr("done count", rdata, expected_done);
    csr_read(CsrLen, rdata);
    check_csr("len", rdata, csr_data_t'(len));
    csr_read(CsrBaseC, rdata);
    check_csr("base c", rdata, csr_data_t'(wc * 4));
    // Whole memory so stray writes show up too
    for (int i = 0; i < MemWords; i++) begin
      check_data($sformatf("mem[%0d]", i), mem_inst.mem[i], model_mem[i]);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'h31f));
    rst           = 1'b1;
    csr_req_addr  = '0;
    csr_req_data  = '0;
    csr_req_write = 1'b0;
    csr_req_valid = 1'b0;
    csr_rsp_ready = 1'b1;
    stall_en      = 1'b0;
    error_count   = 0;
    check_count   = 0;
    test_count    = 0;
    failed_tests  = 0;
    expected_done = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_csr_regs();
    test_rsp_stall();
    // Second half of the jobs with random grant stalls
    for (int j = 0; j < NumJobs; j++) begin
      run_job(j, j >= NumJobs / 2, j % 2 == 1);
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tests/tb_simba_mem.sv */
module tb_simba_mem import simba_pkg::*; #(
  parameter int unsigned Words = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Random grant stalls on all ports
  input  logic                          stall_i,
  input  logic       [NumTcdmPorts-1:0] req_valid_i,
  input  tcdm_addr_t [NumTcdmPorts-1:0] req_addr_i,
  input  logic       [NumTcdmPorts-1:0] req_write_i,
  input  data_t      [NumTcdmPorts-1:0] req_wdata_i,
  output logic       [NumTcdmPorts-1:0] gnt_o,
  output logic       [NumTcdmPorts-1:0] rsp_valid_o,
  output data_t      [NumTcdmPorts-1:0] rsp_rdata_o
);

  localparam int unsigned IdxWidth = $clog2(Words);

  data_t                   mem [Words];
  // Reads granted at the coming rising edge
  logic [NumTcdmPorts-1:0] rd_fire;
  data_t                   rd_data [NumTcdmPorts];

  function automatic int unsigned word_index(input tcdm_addr_t addr);
    return int'(addr[IdxWidth+1:2]);
  endfunction

  initial begin
    gnt_o       = '0;
    rsp_valid_o = '0;
    rsp_rdata_o = '0;
    rd_fire     = '0;
  end

  // All port activity on the falling edge, DUT samples on the rising one
  always @(negedge clk_i) begin
    for (int p = 0; p < NumTcdmPorts; p++) begin
      // Response one cycle after the granted request
      rsp_valid_o[p] = rd_fire[p];
      rsp_rdata_o[p] = rd_fire[p] ? rd_data[p] : '0;
      if (rst_i) begin
        gnt_o[p] = 1'b0;
      end else if (stall_i) begin
        gnt_o[p] = $urandom_range(3, 0) != 0;
      end else begin
        gnt_o[p] = 1'b1;
      end
      // Request is stable until the rising edge
      rd_fire[p] = gnt_o[p] && req_valid_i[p] && !req_write_i[p];
      rd_data[p] = mem[word_index(req_addr_i[p])];
      if (gnt_o[p] && req_valid_i[p] && req_write_i[p]) begin
        mem[word_index(req_addr_i[p])] = req_wdata_i[p];
      end
    end
  end

endmodule

/* verilog/simba_ctrl.sv */
module simba_ctrl import simba_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // CSR request
  input  csr_addr_t  csr_req_addr_i,
  input  csr_data_t  csr_req_data_i,
  input  logic       csr_req_write_i,
  input  logic       csr_req_valid_i,
  output logic       csr_req_ready_o,
  // CSR response
  output csr_data_t  csr_rsp_data_o,
  output logic       csr_rsp_valid_o,
  input  logic       csr_rsp_ready_i,
  // Job launch towards the streamers
  output logic       start_o,
  output tcdm_addr_t base_a_o,
  output tcdm_addr_t base_b_o,
  output tcdm_addr_t base_c_o,
  output len_t       len_o,
  output shift_t     shift_o,
  // Last result write granted
  input  logic       done_i
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        busy;
  logic        req_fire;
  logic        strm_sel;
  logic        cfg_we;
  logic        launch;
  csr_data_t   rd_data;
  logic        rsp_valid_q;
  csr_data_t   rsp_data_q;
  csr_data_t   done_count_q;
  tcdm_addr_t  base_a_q;
  tcdm_addr_t  base_b_q;
  tcdm_addr_t  base_c_q;
  len_t        len_q;
  shift_t      shift_q;

  // ----------------------------------------
  // Request decode
  // ----------------------------------------
  // One outstanding response at most
  assign csr_req_ready_o = !rsp_valid_q;
  assign req_fire        = csr_req_valid_i && csr_req_ready_o;
  // Address split between the two banks
  assign strm_sel        = csr_req_addr_i < StreamerCsrCount;
  assign busy            = state_q != CtrlIdle;
  // Config only changes between jobs
  assign cfg_we          = req_fire && csr_req_write_i && !busy;
  assign launch          = cfg_we && (csr_req_addr_i == CsrStart) && csr_req_data_i[0];

  // Streamer and accelerator register banks
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      base_a_q <= '0;
      base_b_q <= '0;
      base_c_q <= '0;
      len_q    <= '0;
      shift_q  <= '0;
    end else if (cfg_we) begin
      if (strm_sel) begin
        case (csr_req_addr_i)
          CsrBaseA: base_a_q <= tcdm_addr_t'(csr_req_data_i);
          CsrBaseB: base_b_q <= tcdm_addr_t'(csr_req_data_i);
          CsrBaseC: base_c_q <= tcdm_addr_t'(csr_req_data_i);
          CsrLen:   len_q    <= len_t'(csr_req_data_i);
          default: ;
        endcase
      end else if (csr_req_addr_i == CsrShift) begin
        shift_q <= shift_t'(csr_req_data_i);
      end
    end
  end

  // Readback mux, unmapped and start read as zero
  always_comb begin
    rd_data = '0;
    if (strm_sel) begin
      case (csr_req_addr_i)
        CsrBaseA: rd_data = csr_data_t'(base_a_q);
        CsrBaseB: rd_data = csr_data_t'(base_b_q);
        CsrBaseC: rd_data = csr_data_t'(base_c_q);
        CsrLen:   rd_data = csr_data_t'(len_q);
        default:  rd_data = '0;
      endcase
    end else begin
      case (csr_req_addr_i)
        CsrShift:     rd_data = csr_data_t'(shift_q);
        CsrBusy:      rd_data = csr_data_t'(busy);
        CsrDoneCount: rd_data = done_count_q;
        default:      rd_data = '0;
      endcase
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire && !csr_req_write_i) begin
      rsp_valid_q <= 1'b1;
    end else if (csr_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && !csr_req_write_i) begin
      rsp_data_q <= rd_data;
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rsp_data_o  = rsp_data_q;

  // ----------------------------------------
  // Launch FSM
  // ----------------------------------------
  // Run is the strobe cycle, drain waits on the writer
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CtrlIdle:  if (launch) state_d = CtrlRun;
      CtrlRun:   state_d = done_i ? CtrlIdle : CtrlDrain;
      CtrlDrain: if (done_i) state_d = CtrlIdle;
      default:   state_d = CtrlIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= CtrlIdle;
      done_count_q <= '0;
    end else begin
      state_q <= state_d;
      // Completed jobs
      if (busy && done_i) begin
        done_count_q <= done_count_q + 1'b1;
      end
    end
  end

  assign start_o  = state_q == CtrlRun;
  assign base_a_o = base_a_q;
  assign base_b_o = base_b_q;
  assign base_c_o = base_c_q;
  assign len_o    = len_q;
  assign shift_o  = shift_q;

endmodule

/* verilog/simba_mul.sv */
module simba_mul import simba_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  // Result scaling
  input  shift_t shift_i,
  // Operand streams
  input  data_t  a_data_i,
  input  data_t  b_data_i,
  input  logic   a_valid_i,
  input  logic   b_valid_i,
  output logic   a_ready_o,
  output logic   b_ready_o,
  // Result stream
  output data_t  res_data_o,
  output logic   res_valid_o,
  input  logic   res_ready_i
);

  logic  s1_valid_q;
  prod_t s1_prod_q;
  logic  s2_valid_q;
  data_t s2_res_q;
  logic  s1_adv;
  logic  s2_adv;
  logic  in_fire;

  // Stage moves when the next one is free or draining
  assign s2_adv  = !s2_valid_q || res_ready_i;
  assign s1_adv  = !s1_valid_q || s2_adv;
  // Pair taken only when both operands present
  assign in_fire   = a_valid_i && b_valid_i && s1_adv;
  assign a_ready_o = b_valid_i && s1_adv;
  assign b_ready_o = a_valid_i && s1_adv;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_adv) s1_valid_q <= a_valid_i && b_valid_i;
      if (s2_adv) s2_valid_q <= s1_valid_q;
    end
  end

  // Stage one, unsigned full product
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      s1_prod_q <= prod_t'(a_data_i) * prod_t'(b_data_i);
    end
  end

  // Stage two, shift and keep low word
  always_ff @(posedge clk_i) begin
    if (s2_adv && s1_valid_q) begin
      s2_res_q <= data_t'(s1_prod_q >> shift_i);
    end
  end

  assign res_valid_o = s2_valid_q;
  assign res_data_o  = s2_res_q;

endmodule

/* verilog/simba_pkg.sv */
package simba_pkg;

  // ----------------------------------------
  // Datapath and port widths
  // ----------------------------------------
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned TcdmAddrWidth = 20;
  localparam int unsigned CsrWidth      = 32;
  localparam int unsigned LenWidth      = 16;
  localparam int unsigned ShiftWidth    = 5;
  // Reader A, reader B, writer
  localparam int unsigned NumTcdmPorts  = 3;

  // Reader FIFO depth, also the credit limit
  localparam int unsigned FifoDepth    = 4;
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);
  localparam int unsigned FifoCntWidth = $clog2(FifoDepth + 1);

  typedef logic [DataWidth-1:0]     data_t;
  // Full-width product before scaling
  typedef logic [2*DataWidth-1:0]   prod_t;
  typedef logic [TcdmAddrWidth-1:0] tcdm_addr_t;
  typedef logic [CsrWidth-1:0]      csr_addr_t;
  typedef logic [CsrWidth-1:0]      csr_data_t;
  typedef logic [LenWidth-1:0]      len_t;
  typedef logic [ShiftWidth-1:0]    shift_t;
  typedef logic [FifoPtrWidth-1:0]  fifo_ptr_t;
  typedef logic [FifoCntWidth-1:0]  fifo_cnt_t;

  // Byte step from one element to the next
  localparam tcdm_addr_t ElemBytes = tcdm_addr_t'(4);

  // ----------------------------------------
  // CSR map
  // ----------------------------------------
  // Below this, streamer bank
  localparam csr_addr_t StreamerCsrCount = 4;
  localparam csr_addr_t CsrBaseA         = 0;
  localparam csr_addr_t CsrBaseB         = 1;
  localparam csr_addr_t CsrBaseC         = 2;
  localparam csr_addr_t CsrLen           = 3;
  // Accelerator bank
  localparam csr_addr_t CsrShift         = 4;
  localparam csr_addr_t CsrStart         = 5;
  localparam csr_addr_t CsrBusy          = 6;
  localparam csr_addr_t CsrDoneCount     = 7;

  // Launch FSM
  typedef enum logic [1:0] {
    CtrlIdle,
    CtrlRun,
    CtrlDrain
  } ctrl_state_t;

endpackage

/* verilog/simba_reader.sv */
module simba_reader import simba_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Job launch
  input  logic       start_i,
  input  tcdm_addr_t base_i,
  input  len_t       len_i,
  // TCDM read port
  output logic       tcdm_req_valid_o,
  output tcdm_addr_t tcdm_req_addr_o,
  input  logic       tcdm_gnt_i,
  input  logic       tcdm_rsp_valid_i,
  input  data_t      tcdm_rsp_rdata_i,
  // Element stream out
  output data_t      out_data_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  tcdm_addr_t addr_q;
  len_t       left_q;
  fifo_cnt_t  credit_q;
  data_t      fifo_mem [FifoDepth];
  fifo_ptr_t  wr_ptr_q;
  fifo_ptr_t  rd_ptr_q;
  fifo_cnt_t  count_q;
  logic       req_fire;
  logic       pop;

  // Request only with a free FIFO slot reserved
  assign tcdm_req_valid_o = (left_q != '0) && (credit_q != '0);
  assign tcdm_req_addr_o  = addr_q;
  assign req_fire         = tcdm_req_valid_o && tcdm_gnt_i;
  assign out_valid_o      = count_q != '0;
  assign out_data_o       = fifo_mem[rd_ptr_q];
  assign pop              = out_valid_o && out_ready_i;

  // ----------------------------------------
  // Address generator
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      addr_q <= '0;
      left_q <= '0;
    end else if (start_i) begin
      addr_q <= base_i;
      left_q <= len_i;
    end else if (req_fire) begin
      addr_q <= addr_q + ElemBytes;
      left_q <= left_q - 1'b1;
    end
  end

  // Credits = depth - held - in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= fifo_cnt_t'(FifoDepth);
    end else begin
      case ({req_fire, pop})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Response FIFO
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (tcdm_rsp_valid_i) begin
      fifo_mem[wr_ptr_q] <= tcdm_rsp_rdata_i;
    end
  end

  // Pointers wrap on a power of two depth
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (tcdm_rsp_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({tcdm_rsp_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* verilog/simba_top.sv */
module simba_top import simba_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // CSR request
  input  csr_addr_t                     csr_req_addr_i,
  input  csr_data_t                     csr_req_data_i,
  input  logic                          csr_req_write_i,
  input  logic                          csr_req_valid_i,
  output logic                          csr_req_ready_o,
  // CSR response
  output csr_data_t                     csr_rsp_data_o,
  output logic                          csr_rsp_valid_o,
  input  logic                          csr_rsp_ready_i,
  // TCDM, port 0 reader A, 1 reader B, 2 writer
  output logic       [NumTcdmPorts-1:0] tcdm_req_valid_o,
  output tcdm_addr_t [NumTcdmPorts-1:0] tcdm_req_addr_o,
  output logic       [NumTcdmPorts-1:0] tcdm_req_write_o,
  output data_t      [NumTcdmPorts-1:0] tcdm_req_wdata_o,
  input  logic       [NumTcdmPorts-1:0] tcdm_gnt_i,
  input  logic       [NumTcdmPorts-1:0] tcdm_rsp_valid_i,
  input  data_t      [NumTcdmPorts-1:0] tcdm_rsp_rdata_i
);

  // Job configuration
  logic       start;
  logic       done;
  tcdm_addr_t base_a;
  tcdm_addr_t base_b;
  tcdm_addr_t base_c;
  len_t       len;
  shift_t     shift;
  // Streams
  data_t      a_data;
  logic       a_valid;
  logic       a_ready;
  data_t      b_data;
  logic       b_valid;
  logic       b_ready;
  data_t      res_data;
  logic       res_valid;
  logic       res_ready;

  // Reader ports never write
  assign tcdm_req_write_o[1:0] = '0;
  assign tcdm_req_wdata_o[0]   = '0;
  assign tcdm_req_wdata_o[1]   = '0;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  simba_ctrl simba_ctrl_inst (
    .clk_i, .rst_i,
    .csr_req_addr_i, .csr_req_data_i, .csr_req_write_i, .csr_req_valid_i, .csr_req_ready_o,
    .csr_rsp_data_o, .csr_rsp_valid_o, .csr_rsp_ready_i,
    .start_o (start), .base_a_o (base_a), .base_b_o (base_b), .base_c_o (base_c),
    .len_o (len), .shift_o (shift), .done_i (done)
  );

  // ----------------------------------------
  // Operand readers
  // ----------------------------------------
  simba_reader simba_reader_a_inst (
    .clk_i, .rst_i, .start_i (start), .base_i (base_a), .len_i (len),
    .tcdm_req_valid_o (tcdm_req_valid_o[0]), .tcdm_req_addr_o (tcdm_req_addr_o[0]),
    .tcdm_gnt_i (tcdm_gnt_i[0]), .tcdm_rsp_valid_i (tcdm_rsp_valid_i[0]),
    .tcdm_rsp_rdata_i (tcdm_rsp_rdata_i[0]),
    .out_data_o (a_data), .out_valid_o (a_valid), .out_ready_i (a_ready)
  );

  simba_reader simba_reader_b_inst (
    .clk_i, .rst_i, .start_i (start), .base_i (base_b), .len_i (len),
    .tcdm_req_valid_o (tcdm_req_valid_o[1]), .tcdm_req_addr_o (tcdm_req_addr_o[1]),
    .tcdm_gnt_i (tcdm_gnt_i[1]), .tcdm_rsp_valid_i (tcdm_rsp_valid_i[1]),
    .tcdm_rsp_rdata_i (tcdm_rsp_rdata_i[1]),
    .out_data_o (b_data), .out_valid_o (b_valid), .out_ready_i (b_ready)
  );

  // Multiply and scale
  simba_mul simba_mul_inst (
    .clk_i, .rst_i, .shift_i (shift),
    .a_data_i (a_data), .b_data_i (b_data), .a_valid_i (a_valid), .b_valid_i (b_valid),
    .a_ready_o (a_ready), .b_ready_o (b_ready),
    .res_data_o (res_data), .res_valid_o (res_valid), .res_ready_i (res_ready)
  );

  // Result writer on port 2
  simba_writer simba_writer_inst (
    .clk_i, .rst_i, .start_i (start), .base_i (base_c), .len_i (len),
    .in_data_i (res_data), .in_valid_i (res_valid), .in_ready_o (res_ready),
    .tcdm_req_valid_o (tcdm_req_valid_o[2]), .tcdm_req_addr_o (tcdm_req_addr_o[2]),
    .tcdm_req_write_o (tcdm_req_write_o[2]), .tcdm_req_wdata_o (tcdm_req_wdata_o[2]),
    .tcdm_gnt_i (tcdm_gnt_i[2]), .done_o (done)
  );

endmodule

/* verilog/simba_writer.sv */
module simba_writer import simba_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Job launch
  input  logic       start_i,
  input  tcdm_addr_t base_i,
  input  len_t       len_i,
  // Result stream in
  input  data_t      in_data_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  // TCDM write port
  output logic       tcdm_req_valid_o,
  output tcdm_addr_t tcdm_req_addr_o,
  output logic       tcdm_req_write_o,
  output data_t      tcdm_req_wdata_o,
  input  logic       tcdm_gnt_i,
  // Last write granted
  output logic       done_o
);

  logic       active_q;
  tcdm_addr_t addr_q;
  len_t       len_q;
  len_t       count_q;
  logic       req_fire;
  logic       last;

  // Result passes straight onto the port
  assign tcdm_req_valid_o = active_q && in_valid_i;
  assign tcdm_req_addr_o  = addr_q;
  assign tcdm_req_write_o = 1'b1;
  assign tcdm_req_wdata_o = in_data_i;
  assign in_ready_o       = active_q && tcdm_gnt_i;
  assign req_fire         = tcdm_req_valid_o && tcdm_gnt_i;
  assign last             = count_q == (len_q - 1'b1);
  // Empty job finishes at once
  assign done_o = (req_fire && last) || (start_i && (len_i == '0));

  // Address generator and completion count
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      addr_q   <= '0;
      len_q    <= '0;
      count_q  <= '0;
    end else if (start_i) begin
      active_q <= len_i != '0;
      addr_q   <= base_i;
      len_q    <= len_i;
      count_q  <= '0;
    end else if (req_fire) begin
      addr_q  <= addr_q + ElemBytes;
      count_q <= count_q + 1'b1;
      if (last) active_q <= 1'b0;
    end
  end

endmodule
